// File: slurm16_pkg.sv
`default_nettype none

package slurm16_pkg;

	localparam int BITS          = 16;	/* Data path width */
	localparam int ADDRESS_BITS  = 16;	/* Memory and port address width */
	localparam int REGISTER_BITS = 4;	/* Register select width */
	localparam int PC_BITS       = 15;	/* Word address, byte address appends a zero */

	/* Instruction field positions */
	localparam int OPCODE_MSB    = 15;
	localparam int OPCODE_LSB    = 12;
	localparam int FIELD_HI_MSB  = 11;	/* ALU op, condition or register */
	localparam int FIELD_HI_LSB  = 8;
	localparam int FIELD_MID_MSB = 7;
	localparam int FIELD_MID_LSB = 4;
	localparam int FIELD_LO_MSB  = 3;
	localparam int FIELD_LO_LSB  = 0;
	localparam int IMM_MSB       = 7;	/* LDI immediate and branch offset */
	localparam int IMM_LSB       = 0;
	localparam int IMM_BITS      = IMM_MSB - IMM_LSB + 1;

	/* Unlisted opcodes run as NOP */
	typedef enum logic [3:0] {
		NOP   = 4'h0,
		ALU_R = 4'h1,
		LDI   = 4'h2,
		BR    = 4'h3,
		OUT   = 4'h4,
		IN    = 4'h5,
		HALT  = 4'hf
	} opcode_t;

	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		MOV = 4'h5,
		SHL = 4'h6,	/* Destination shifted left by one */
		SHR = 4'h7	/* Destination shifted right by one, logical */
	} alu_op_t;

	typedef enum logic [3:0] {
		ALWAYS = 4'h0,
		EQ     = 4'h1,	/* Z set */
		NE     = 4'h2,
		CS     = 4'h3,	/* C set */
		CC     = 4'h4,
		MI     = 4'h5,	/* S set */
		PL     = 4'h6,
		VS     = 4'h7	/* V set */
	} cond_t;

endpackage

`default_nettype wire

// File: slurm16_cpu_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module slurm16_cpu_fetch import slurm16_pkg::*; #(
	parameter int QUEUE_DEPTH = 4,
	localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1)
) (
	input  logic                      clk,
	input  logic                      rst_n,

	output logic [ADDRESS_BITS - 1:0] memory_address,
	output logic                      memory_valid,
	input  logic                      memory_ready,
	input  logic [BITS - 1:0]         memory_in,

	input  logic [COUNT_BITS - 1:0]   queue_count,
	output logic                      queue_push,
	output logic [BITS - 1:0]         queue_word_in,
	output logic [PC_BITS - 1:0]      queue_address_in,

	input  logic                      load_pc_request,
	input  logic [PC_BITS - 1:0]      load_pc_address
);

logic [PC_BITS - 1:0] pc;	/* Next word to request */
logic [PC_BITS - 1:0] req_pc;	/* Word of the request on the pins */
logic [PC_BITS - 1:0] pc_src;
logic discard;	/* In-flight response belongs to an old stream */
logic fetch_done;
logic outstanding;
logic issue;
logic [COUNT_BITS - 1:0] count_eff;
logic [COUNT_BITS:0] occupancy;

assign memory_address = {req_pc, 1'b0};
assign queue_word_in = memory_in;
assign queue_address_in = req_pc;

always_comb begin
	fetch_done = memory_valid && memory_ready;
	outstanding = memory_valid && !memory_ready;
	queue_push = fetch_done && !discard && !load_pc_request;
	count_eff = load_pc_request ? '0 : queue_count;	/* Queue is flushed this cycle */
	occupancy = {1'b0, count_eff} + {{COUNT_BITS{1'b0}}, queue_push}
		+ {{COUNT_BITS{1'b0}}, outstanding};
	issue = !outstanding && (occupancy < QUEUE_DEPTH);
	pc_src = load_pc_request ? load_pc_address : pc;
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		memory_valid <= 1'b0;
		pc <= '0;
		req_pc <= '0;
		discard <= 1'b0;
	end else begin
		if (issue) begin
			memory_valid <= 1'b1;
			req_pc <= pc_src;
			pc <= pc_src + 1'b1;
		end else begin
			if (fetch_done)
				memory_valid <= 1'b0;	/* Queue full, hold off */
			if (load_pc_request)
				pc <= load_pc_address;
		end

		if (load_pc_request && outstanding)
			discard <= 1'b1;	/* Let the pins finish, drop the word */
		else if (fetch_done)
			discard <= 1'b0;
	end
end

endmodule

`default_nettype wire

// File: slurm16_cpu_instruction_queue.sv
`timescale 1ns/100ps
`default_nettype none

module slurm16_cpu_instruction_queue import slurm16_pkg::*; #(
	parameter int QUEUE_DEPTH = 4,
	localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1)
) (
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    queue_push,
	input  logic [BITS - 1:0]       queue_word_in,
	input  logic [PC_BITS - 1:0]    queue_address_in,
	input  logic                    queue_pop,
	input  logic                    flush,

	output logic [BITS - 1:0]       queue_word,
	output logic [PC_BITS - 1:0]    queue_address,
	output logic                    queue_empty,
	output logic [COUNT_BITS - 1:0] queue_count
);

localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

logic [BITS - 1:0] word_mem [QUEUE_DEPTH];
logic [PC_BITS - 1:0] address_mem [QUEUE_DEPTH];
logic [PTR_BITS - 1:0] rd_ptr;
logic [PTR_BITS - 1:0] wr_ptr;
logic do_push;
logic do_pop;

/* Wraps for any depth, not only powers of two */
function automatic logic [PTR_BITS - 1:0] ptr_inc(input logic [PTR_BITS - 1:0] ptr);
	if (ptr == PTR_BITS'(QUEUE_DEPTH - 1))
		return '0;
	return ptr + 1'b1;
endfunction

assign queue_empty = (queue_count == '0);
assign do_push = queue_push && (queue_count != COUNT_BITS'(QUEUE_DEPTH));
assign do_pop = queue_pop && !queue_empty;
assign queue_word = word_mem[rd_ptr];	/* Head is visible without a pop */
assign queue_address = address_mem[rd_ptr];

always_ff @(posedge clk) begin
	if (!rst_n || flush) begin	/* Flush wins over push and pop */
		rd_ptr <= '0;
		wr_ptr <= '0;
		queue_count <= '0;
	end else begin
		if (do_push)
			wr_ptr <= ptr_inc(wr_ptr);
		if (do_pop)
			rd_ptr <= ptr_inc(rd_ptr);
		if (do_push && !do_pop)
			queue_count <= queue_count + 1'b1;
		else if (do_pop && !do_push)
			queue_count <= queue_count - 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (do_push) begin
		word_mem[wr_ptr] <= queue_word_in;
		address_mem[wr_ptr] <= queue_address_in;
	end
end

endmodule

`default_nettype wire

// File: slurm16_cpu_registers.sv
`timescale 1ns/100ps
`default_nettype none

module slurm16_cpu_registers import slurm16_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic [REGISTER_BITS - 1:0] reg_a_sel,
	input  logic [REGISTER_BITS - 1:0] reg_b_sel,
	output logic [BITS - 1:0]          reg_a,
	output logic [BITS - 1:0]          reg_b,

	input  logic                       reg_wr,
	input  logic [REGISTER_BITS - 1:0] reg_wr_sel,
	input  logic [BITS - 1:0]          reg_wr_data
);

localparam int REGISTERS = 2 ** REGISTER_BITS;

logic [BITS - 1:0] regs [REGISTERS];

assign reg_a = regs[reg_a_sel];	/* Asynchronous reads */
assign reg_b = regs[reg_b_sel];

always_ff @(posedge clk) begin
	if (!rst_n) begin
		for (int i = 0; i < REGISTERS; i++)
			regs[i] <= '0;
	end else if (reg_wr) begin
		regs[reg_wr_sel] <= reg_wr_data;
	end
end

endmodule

`default_nettype wire

// File: slurm16_cpu_alu.sv
`timescale 1ns/100ps
`default_nettype none

module slurm16_cpu_alu import slurm16_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,

	input  alu_op_t           alu_op,
	input  logic [BITS - 1:0] alu_a,	/* Destination register */
	input  logic [BITS - 1:0] alu_b,	/* Source register */
	output logic [BITS - 1:0] alu_out,

	input  logic              flags_load,
	output logic              z,
	output logic              c,
	output logic              s,
	output logic              v
);

logic c_next;
logic v_next;

always_comb begin
	c_next = 1'b0;
	v_next = 1'b0;
	case (alu_op)
		ADD: begin
			{c_next, alu_out} = {1'b0, alu_a} + {1'b0, alu_b};
			v_next = (alu_a[BITS - 1] == alu_b[BITS - 1])
				&& (alu_out[BITS - 1] != alu_a[BITS - 1]);
		end
		SUB: begin
			{c_next, alu_out} = {1'b0, alu_a} - {1'b0, alu_b};	/* Carry is borrow */
			v_next = (alu_a[BITS - 1] != alu_b[BITS - 1])
				&& (alu_out[BITS - 1] != alu_a[BITS - 1]);
		end
		AND: alu_out = alu_a & alu_b;
		OR:  alu_out = alu_a | alu_b;
		XOR: alu_out = alu_a ^ alu_b;
		MOV: alu_out = alu_b;
		SHL: {c_next, alu_out} = {alu_a, 1'b0};
		SHR: {alu_out, c_next} = {1'b0, alu_a};
		default: alu_out = '0;
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		z <= 1'b0;
		c <= 1'b0;
		s <= 1'b0;
		v <= 1'b0;
	end else if (flags_load) begin
		z <= (alu_out == '0);
		c <= c_next;
		s <= alu_out[BITS - 1];
		v <= v_next;
	end
end

endmodule

`default_nettype wire

// File: slurm16_cpu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module slurm16_cpu_execute import slurm16_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic [BITS - 1:0]          queue_word,
	input  logic [PC_BITS - 1:0]       queue_address,
	input  logic                       queue_empty,
	output logic                       queue_pop,

	output logic [REGISTER_BITS - 1:0] reg_a_sel,
	output logic [REGISTER_BITS - 1:0] reg_b_sel,
	input  logic [BITS - 1:0]          reg_a,
	input  logic [BITS - 1:0]          reg_b,
	output logic                       reg_wr,
	output logic [REGISTER_BITS - 1:0] reg_wr_sel,
	output logic [BITS - 1:0]          reg_wr_data,

	output alu_op_t                    alu_op,
	output logic [BITS - 1:0]          alu_a,
	output logic [BITS - 1:0]          alu_b,
	input  logic [BITS - 1:0]          alu_out,
	output logic                       flags_load,
	input  logic                       z,
	input  logic                       c,
	input  logic                       s,
	input  logic                       v,

	output logic                       load_pc_request,
	output logic [PC_BITS - 1:0]       load_pc_address,

	output logic [ADDRESS_BITS - 1:0]  port_address,
	output logic [BITS - 1:0]          port_out,
	output logic                       port_rd,
	output logic                       port_wr,
	input  logic [BITS - 1:0]          port_in,

	output logic                       halted
);

typedef enum logic [1:0] {
	RUN,
	IN_WAIT,	/* Port data arrives this cycle */
	HALTED
} state_t;

state_t state;
state_t state_next;
opcode_t opcode;
cond_t cond;
logic [REGISTER_BITS - 1:0] field_hi;
logic [REGISTER_BITS - 1:0] field_mid;
logic [REGISTER_BITS - 1:0] field_lo;
logic [IMM_BITS - 1:0] imm;
logic active;
logic cond_pass;

assign opcode = opcode_t'(queue_word[OPCODE_MSB:OPCODE_LSB]);
assign cond = cond_t'(queue_word[FIELD_HI_MSB:FIELD_HI_LSB]);
assign field_hi = queue_word[FIELD_HI_MSB:FIELD_HI_LSB];
assign field_mid = queue_word[FIELD_MID_MSB:FIELD_MID_LSB];
assign field_lo = queue_word[FIELD_LO_MSB:FIELD_LO_LSB];
assign imm = queue_word[IMM_MSB:IMM_LSB];
assign active = (state == RUN) && !queue_empty;

/* OUT takes the port address from bits 11:8, everything else reads bits 7:4 first */
assign reg_a_sel = (opcode == OUT) ? field_hi : field_mid;
assign reg_b_sel = (opcode == OUT) ? field_mid : field_lo;
assign alu_op = alu_op_t'(field_hi);
assign alu_a = reg_a;
assign alu_b = reg_b;
assign port_address = reg_a;
assign port_out = reg_b;
assign load_pc_address = queue_address + {{(PC_BITS - IMM_BITS){imm[IMM_BITS - 1]}}, imm};
assign halted = (state == HALTED);

always_comb begin
	case (cond)
		ALWAYS:  cond_pass = 1'b1;
		EQ:      cond_pass = z;
		NE:      cond_pass = !z;
		CS:      cond_pass = c;
		CC:      cond_pass = !c;
		MI:      cond_pass = s;
		PL:      cond_pass = !s;
		VS:      cond_pass = v;
		default: cond_pass = 1'b0;
	endcase
end

always_comb begin
	queue_pop = 1'b0;
	reg_wr = 1'b0;
	reg_wr_sel = field_hi;
	reg_wr_data = alu_out;
	flags_load = 1'b0;
	load_pc_request = 1'b0;
	port_rd = 1'b0;
	port_wr = 1'b0;
	state_next = state;

	if (state == IN_WAIT) begin
		reg_wr = 1'b1;
		reg_wr_data = port_in;
		queue_pop = 1'b1;	/* IN retires now */
		state_next = RUN;
	end else if (active) begin
		case (opcode)
			ALU_R: begin
				queue_pop = 1'b1;
				reg_wr = 1'b1;
				reg_wr_sel = field_mid;
				flags_load = 1'b1;
			end
			LDI: begin
				queue_pop = 1'b1;
				reg_wr = 1'b1;
				reg_wr_data = {{(BITS - IMM_BITS){1'b0}}, imm};
			end
			BR: begin
				queue_pop = 1'b1;
				load_pc_request = cond_pass;	/* Also flushes the queue */
			end
			OUT: begin
				queue_pop = 1'b1;
				port_wr = 1'b1;
			end
			IN: begin
				port_rd = 1'b1;	/* Word stays at the head one more cycle */
				state_next = IN_WAIT;
			end
			HALT: state_next = HALTED;
			default: queue_pop = 1'b1;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (!rst_n)
		state <= RUN;
	else
		state <= state_next;
end

endmodule

`default_nettype wire

// File: slurm16_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module slurm16_cpu_top import slurm16_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,

	output logic [ADDRESS_BITS - 1:0] memory_address,
	output logic                      memory_valid,	/* Held until memory_ready */
	input  logic                      memory_ready,
	input  logic [BITS - 1:0]         memory_in,

	output logic [ADDRESS_BITS - 1:0] port_address,
	output logic [BITS - 1:0]         port_out,
	input  logic [BITS - 1:0]         port_in,
	output logic                      port_rd,
	output logic                      port_wr,

	output logic                      halted
);

localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

logic [COUNT_BITS - 1:0] queue_count;
logic queue_push;
logic [BITS - 1:0] queue_word_in;
logic [PC_BITS - 1:0] queue_address_in;
logic queue_pop;
logic [BITS - 1:0] queue_word;
logic [PC_BITS - 1:0] queue_address;
logic queue_empty;

logic load_pc_request;
logic [PC_BITS - 1:0] load_pc_address;

logic [REGISTER_BITS - 1:0] reg_a_sel;
logic [REGISTER_BITS - 1:0] reg_b_sel;
logic [BITS - 1:0] reg_a;
logic [BITS - 1:0] reg_b;
logic reg_wr;
logic [REGISTER_BITS - 1:0] reg_wr_sel;
logic [BITS - 1:0] reg_wr_data;

alu_op_t alu_op;
logic [BITS - 1:0] alu_a;
logic [BITS - 1:0] alu_b;
logic [BITS - 1:0] alu_out;
logic flags_load;
logic z;
logic c;
logic s;
logic v;

slurm16_cpu_fetch #(.QUEUE_DEPTH(QUEUE_DEPTH)) fetch0 (
	.clk(clk), .rst_n(rst_n),
	.memory_address(memory_address), .memory_valid(memory_valid),
	.memory_ready(memory_ready), .memory_in(memory_in),
	.queue_count(queue_count), .queue_push(queue_push),
	.queue_word_in(queue_word_in), .queue_address_in(queue_address_in),
	.load_pc_request(load_pc_request), .load_pc_address(load_pc_address)
);

slurm16_cpu_instruction_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
	.clk(clk), .rst_n(rst_n),
	.queue_push(queue_push), .queue_word_in(queue_word_in),
	.queue_address_in(queue_address_in), .queue_pop(queue_pop),
	.flush(load_pc_request),	/* Taken branch empties the queue */
	.queue_word(queue_word), .queue_address(queue_address),
	.queue_empty(queue_empty), .queue_count(queue_count)
);

slurm16_cpu_execute exec0 (
	.clk(clk), .rst_n(rst_n),
	.queue_word(queue_word), .queue_address(queue_address),
	.queue_empty(queue_empty), .queue_pop(queue_pop),
	.reg_a_sel(reg_a_sel), .reg_b_sel(reg_b_sel), .reg_a(reg_a), .reg_b(reg_b),
	.reg_wr(reg_wr), .reg_wr_sel(reg_wr_sel), .reg_wr_data(reg_wr_data),
	.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_out(alu_out),
	.flags_load(flags_load), .z(z), .c(c), .s(s), .v(v),
	.load_pc_request(load_pc_request), .load_pc_address(load_pc_address),
	.port_address(port_address), .port_out(port_out),
	.port_rd(port_rd), .port_wr(port_wr), .port_in(port_in),
	.halted(halted)
);

slurm16_cpu_registers reg0 (
	.clk(clk), .rst_n(rst_n),
	.reg_a_sel(reg_a_sel), .reg_b_sel(reg_b_sel), .reg_a(reg_a), .reg_b(reg_b),
	.reg_wr(reg_wr), .reg_wr_sel(reg_wr_sel), .reg_wr_data(reg_wr_data)
);

slurm16_cpu_alu alu0 (
	.clk(clk), .rst_n(rst_n),
	.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_out(alu_out),
	.flags_load(flags_load), .z(z), .c(c), .s(s), .v(v)
);

endmodule

`default_nettype wire

// File: tb_slurm16_cpu_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module tb_slurm16_cpu_asserts import slurm16_pkg::*; (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      memory_valid,
	input logic                      memory_ready,
	input logic [ADDRESS_BITS - 1:0] memory_address,
	input logic                      port_rd,
	input logic                      port_wr
);

int failures = 0;	// Read by the testbench at the end of the run

// A raised request holds its address until the ready pulse
property request_held;
	@(posedge clk) disable iff (!rst_n)
		memory_valid && !memory_ready |=> memory_valid && $stable(memory_address);
endproperty

property port_strobes_exclusive;
	@(posedge clk) disable iff (!rst_n)
		!(port_rd && port_wr);
endproperty

property quiet_after_reset;
	@(posedge clk) $rose(rst_n) |-> !memory_valid && !port_rd && !port_wr;
endproperty

request_held_check: assert property (request_held)
	else begin
		$error("memory request dropped or changed before memory_ready");
		failures++;
	end

port_strobes_check: assert property (port_strobes_exclusive)
	else begin
		$error("port_rd and port_wr high in the same cycle");
		failures++;
	end

reset_state_check: assert property (quiet_after_reset)
	else begin
		$error("memory or port strobe high in the first cycle after reset");
		failures++;
	end

endmodule

bind slurm16_cpu_top tb_slurm16_cpu_asserts u_asserts (
	.clk(clk), .rst_n(rst_n),
	.memory_valid(memory_valid), .memory_ready(memory_ready),
	.memory_address(memory_address),
	.port_rd(port_rd), .port_wr(port_wr)
);

`default_nettype wire

// File: tb_slurm16_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_slurm16_cpu import slurm16_pkg::*;;

localparam int CLK_PERIOD = 40;
localparam int QUEUE_DEPTH = 4;
localparam int TESTS = 5;
localparam int CYCLES_PER_TEST = 500;
localparam int HALT_TIMEOUT = 400;	// Cycles, leaves room for reset and the checks

logic clk;
logic rst_n;
logic [ADDRESS_BITS - 1:0] memory_address;
logic memory_valid;
logic memory_ready;
logic [BITS - 1:0] memory_in;
logic [ADDRESS_BITS - 1:0] port_address;
logic [BITS - 1:0] port_out;
logic [BITS - 1:0] port_in;
logic port_rd;
logic port_wr;
logic halted;

logic [BITS - 1:0] program_mem [256];
int load_ptr;
logic [15:0] lfsr = 16'd12;
logic [1:0] wait_left;
logic [ADDRESS_BITS - 1:0] write_address_q [$];	// Captured port writes
logic [BITS - 1:0] write_data_q [$];
logic [ADDRESS_BITS - 1:0] exp_address_q [$];
logic [BITS - 1:0] exp_data_q [$];
string test_name;
int test_errors;
int total_errors;
int tests_failed;
int tests_run;
int check_count;

slurm16_cpu_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (
	.clk(clk), .rst_n(rst_n),
	.memory_address(memory_address), .memory_valid(memory_valid),
	.memory_ready(memory_ready), .memory_in(memory_in),
	.port_address(port_address), .port_out(port_out), .port_in(port_in),
	.port_rd(port_rd), .port_wr(port_wr),
	.halted(halted)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
	#(TESTS * CYCLES_PER_TEST * CLK_PERIOD);
	$display("Error at %0t ns: watchdog expired, run did not complete", $time);
	$display("SIMULATION FAILED");
	$finish;
end

function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};	// x^16+x^14+x^13+x^11+1
endfunction

function automatic logic [1:0] random_wait();
	logic [1:0] bits;
	for (int i = 0; i < 2; i++) begin
		lfsr = lfsr_step(lfsr);	// One step per bit taken
		bits[i] = lfsr[0];
	end
	return bits;
endfunction

// Memory with 0 to 3 wait states per request
always @(posedge clk) begin
	if (!rst_n) begin
		memory_ready <= 1'b0;
		wait_left <= random_wait();
	end else if (memory_ready) begin
		memory_ready <= 1'b0;	// Single-cycle pulse
	end else if (memory_valid) begin
		if (wait_left == 2'd0) begin
			memory_ready <= 1'b1;
			memory_in <= program_mem[memory_address[8:1]];
			wait_left <= random_wait();
		end else begin
			wait_left <= wait_left - 1'b1;
		end
	end
end

// Port model, reads return the address plus 0x1000
always @(posedge clk) begin
	if (rst_n && port_rd)
		port_in <= port_address + 16'h1000;
	if (rst_n && port_wr) begin
		write_address_q.push_back(port_address);
		write_data_q.push_back(port_out);
	end
end

function automatic logic [BITS - 1:0] alu_word(input alu_op_t op, input logic [3:0] rd,
	input logic [3:0] rs);
	return {ALU_R, op, rd, rs};
endfunction

function automatic logic [BITS - 1:0] ldi_word(input logic [3:0] rd, input logic [7:0] imm);
	return {LDI, rd, imm};
endfunction

function automatic logic [BITS - 1:0] br_word(input cond_t cond, input logic [7:0] offset);
	return {BR, cond, offset};
endfunction

function automatic logic [BITS - 1:0] out_word(input logic [3:0] addr_reg, input logic [3:0] data_reg);
	return {OUT, addr_reg, data_reg, 4'h0};
endfunction

function automatic logic [BITS - 1:0] in_word(input logic [3:0] rd, input logic [3:0] addr_reg);
	return {IN, rd, addr_reg, 4'h0};
endfunction

function automatic logic [BITS - 1:0] expected_alu(input alu_op_t op, input logic [BITS - 1:0] a,
	input logic [BITS - 1:0] b);
	case (op)
		ADD: return a + b;
		SUB: return a - b;
		AND: return a & b;
		OR:  return a | b;
		XOR: return a ^ b;
		MOV: return b;
		SHL: return a << 1;
		SHR: return a >> 1;
		default: return '0;
	endcase
endfunction

// Branch outcome after SUB a, b, from the flag rules
function automatic logic cond_taken(input cond_t cond, input logic [BITS - 1:0] a,
	input logic [BITS - 1:0] b);
	logic [BITS - 1:0] result;
	int signed_diff;
	logic zf;
	logic cf;
	logic sf;
	logic vf;
	result = a - b;
	signed_diff = int'($signed(a)) - int'($signed(b));
	zf = (result == '0);
	cf = (a < b);	// Borrow
	sf = result[BITS - 1];
	vf = (signed_diff > 32767) || (signed_diff < -32768);
	case (cond)
		ALWAYS: return 1'b1;
		EQ: return zf;
		NE: return !zf;
		CS: return cf;
		CC: return !cf;
		MI: return sf;
		PL: return !sf;
		VS: return vf;
		default: return 1'b0;
	endcase
endfunction

task automatic emit(input logic [BITS - 1:0] word);
	program_mem[load_ptr] = word;
	load_ptr++;
endtask

task automatic expect_write(input logic [ADDRESS_BITS - 1:0] addr, input logic [BITS - 1:0] data);
	exp_address_q.push_back(addr);
	exp_data_q.push_back(data);
endtask

task automatic compare_data(input string name, input logic [BITS - 1:0] got,
	input logic [BITS - 1:0] exp);
	check_count++;
	if (got !== exp) begin
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		test_errors++;
	end
endtask

task automatic compare_address(input string name, input logic [ADDRESS_BITS - 1:0] got,
	input logic [ADDRESS_BITS - 1:0] exp);
	check_count++;
	if (got !== exp) begin
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		test_errors++;
	end
endtask

task automatic compare_count(input string name, input int got, input int exp);
	check_count++;
	if (got != exp) begin
		$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		test_errors++;
	end
endtask

// Holds reset, then clears the program and the write lists
task automatic begin_test(input string name);
	@(posedge clk);
	rst_n <= 1'b0;
	@(posedge clk);
	test_name = name;
	test_errors = 0;
	load_ptr = 0;
	for (int i = 0; i < 256; i++)
		program_mem[i] = {HALT, 4'h0, 8'(i)};	// Fill differs per word
	write_address_q.delete();
	write_data_q.delete();
	exp_address_q.delete();
	exp_data_q.delete();
endtask

task automatic run_to_halt();
	int cycles;
	repeat (2) @(posedge clk);
	rst_n <= 1'b1;
	cycles = 0;
	while (!halted && cycles < HALT_TIMEOUT) begin
		@(posedge clk);
		cycles++;
	end
	if (!halted) begin
		$display("Error at %0t ns: CPU did not halt within %0d cycles", $time, HALT_TIMEOUT);
		test_errors++;
	end
	repeat (10) @(posedge clk);	// Late writes would show up here
endtask

task automatic finish_test();
	int n;
	compare_count("port_wr count", write_address_q.size(), exp_address_q.size());
	n = (write_address_q.size() < exp_address_q.size()) ? write_address_q.size()
		: exp_address_q.size();
	for (int i = 0; i < n; i++) begin
		compare_address($sformatf("port_address[%0d]", i), write_address_q[i], exp_address_q[i]);
		compare_data($sformatf("port_out[%0d]", i), write_data_q[i], exp_data_q[i]);
	end
	tests_run++;
	if (test_errors != 0)
		tests_failed++;
	total_errors += test_errors;
	$display("Test %-14s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "failing",
		test_errors);
endtask

task automatic test_alu_ldi();
	alu_op_t op;
	begin_test("alu_ldi");
	emit(ldi_word(4'd1, 8'hc5));
	emit(ldi_word(4'd2, 8'h3a));
	for (int k = 0; k < 8; k++) begin
		op = alu_op_t'(k);
		emit(ldi_word(4'd4, 8'(8'h10 + k)));
		emit(alu_word(MOV, 4'd3, 4'd1));	// r3 = r1
		emit(alu_word(op, 4'd3, 4'd2));
		emit(out_word(4'd4, 4'd3));
		expect_write(16'h0010 + 16'(k), expected_alu(op, 16'h00c5, 16'h003a));
	end
	emit({HALT, 12'h000});
	run_to_halt();
	finish_test();
endtask

task automatic test_conditions();
	logic [BITS - 1:0] value [16];
	logic [3:0] a_sel [8] = '{4'd1, 4'd1, 4'd1, 4'd2, 4'd2, 4'd2, 4'd1, 4'd9};
	logic [3:0] b_sel [8] = '{4'd2, 4'd1, 4'd1, 4'd1, 4'd1, 4'd1, 4'd2, 4'd10};
	begin_test("conditions");
	value[1] = 16'h0005;
	value[2] = 16'h0003;
	value[9] = 16'h8000;
	value[10] = 16'h0001;
	emit(ldi_word(4'd1, 8'h05));
	emit(ldi_word(4'd2, 8'h03));
	emit(ldi_word(4'd9, 8'h80));
	repeat (8) emit(alu_word(SHL, 4'd9, 4'd0));	// r9 = 0x8000
	emit(ldi_word(4'd10, 8'h01));
	emit(ldi_word(4'd6, 8'h55));	// Fall-through marker
	emit(ldi_word(4'd7, 8'haa));	// Taken marker
	for (int k = 0; k < 8; k++) begin
		emit(ldi_word(4'd5, 8'(8'h20 + k)));
		emit(alu_word(MOV, 4'd3, a_sel[k]));
		emit(alu_word(SUB, 4'd3, b_sel[k]));
		emit(br_word(cond_t'(k), 8'd3));
		emit(out_word(4'd5, 4'd6));
		emit(br_word(ALWAYS, 8'd2));
		emit(out_word(4'd5, 4'd7));
		expect_write(16'h0020 + 16'(k),
			cond_taken(cond_t'(k), value[a_sel[k]], value[b_sel[k]]) ? 16'h00aa : 16'h0055);
	end
	emit({HALT, 12'h000});
	run_to_halt();
	finish_test();
endtask

task automatic test_branch_flush();
	begin_test("branch_flush");
	emit(ldi_word(4'd5, 8'h30));
	emit(ldi_word(4'd7, 8'hee));	// Only the skipped OUTs write this
	for (int k = 1; k <= 4; k++) begin
		emit(ldi_word(4'd6, 8'(8'h11 * k)));
		emit(br_word(ALWAYS, 8'd5));
		repeat (4) emit(out_word(4'd5, 4'd7));
		emit(out_word(4'd5, 4'd6));
		expect_write(16'h0030, 16'(8'h11 * k));
	end
	emit({HALT, 12'h000});
	run_to_halt();
	finish_test();
endtask

task automatic test_in_port();
	logic [7:0] addr [4] = '{8'h40, 8'h7f, 8'h00, 8'hc3};
	begin_test("in_port");
	emit(ldi_word(4'd3, 8'h50));
	for (int k = 0; k < 4; k++) begin
		emit(ldi_word(4'd1, addr[k]));
		emit(in_word(4'd2, 4'd1));
		emit(out_word(4'd3, 4'd2));	// Uses the IN result right away
		expect_write(16'h0050, 16'h1000 + 16'(addr[k]));
	end
	emit({HALT, 12'h000});
	run_to_halt();
	finish_test();
endtask

task automatic test_halt_backpressure();
	int cycles;
	logic woke;
	begin_test("halt_queue");
	emit(ldi_word(4'd1, 8'h60));
	for (int k = 0; k < 6; k++) begin
		emit(ldi_word(4'd2, 8'(k * 7 + 1)));
		emit(out_word(4'd1, 4'd2));
		expect_write(16'h0060, 16'(k * 7 + 1));
	end
	emit({HALT, 12'h000});
	repeat (4) emit(out_word(4'd1, 4'd1));	// Must never run
	run_to_halt();
	cycles = 0;
	while (memory_valid && cycles < 40) begin
		@(posedge clk);
		cycles++;
	end
	if (memory_valid) begin
		$display("Error at %0t ns: fetch still requesting long after HALT", $time);
		test_errors++;
	end
	woke = 1'b0;
	repeat (30) begin
		@(posedge clk);
		if (memory_valid)
			woke = 1'b1;
	end
	if (woke) begin
		$display("Error at %0t ns: fetch resumed with a full queue", $time);
		test_errors++;
	end
	finish_test();
endtask

initial begin
	rst_n = 1'b0;
	memory_ready = 1'b0;
	memory_in = '0;
	port_in = '0;
	total_errors = 0;
	tests_failed = 0;
	tests_run = 0;
	check_count = 0;
	test_alu_ldi();
	test_conditions();
	test_branch_flush();
	test_in_port();
	test_halt_backpressure();
	$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
		tests_run, tests_failed, check_count, total_errors, u_dut.u_asserts.failures);
	if (total_errors == 0 && u_dut.u_asserts.failures == 0) begin
		$display("SIMULATION PASSED");
	end else begin
		$display("SIMULATION FAILED");
	end
	$finish;
end

endmodule

`default_nettype wire

// File: project.f
slurm16_pkg.sv
slurm16_cpu_fetch.sv
slurm16_cpu_instruction_queue.sv
slurm16_cpu_registers.sv
slurm16_cpu_alu.sv
slurm16_cpu_execute.sv
slurm16_cpu_top.sv
tb_slurm16_cpu_asserts.sv
tb_slurm16_cpu.sv
